/* include/axi_sram_defs.svh */
//**************************************
// axi-lite sram build-time sizes
// bus widths, memory depth, read delay
//**************************************
`ifndef AXI_SRAM_DEFS_SVH
`define AXI_SRAM_DEFS_SVH

// byte address width on the bus
`define AXI_ADDR_W 32

// data width, fixed by the four-bit strobe
`define AXI_DATA_W 32

// log2 of the number of memory words
`define MEM_WORDS_LOG2 10

// cycles between req and done for a valid read, at least 2
`define READ_WAIT 7

`endif

/* run.sh */
#!/bin/sh
# builds the axi-lite sram testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	--top-module axi_sram_tb -f vlog.f -o axi_sram_sim

# a fatal stop exits nonzero, the log search below gives the verdict
./obj_dir/axi_sram_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

/* tests/axi_sram_chk.sv */
//****************************************
// axi-lite sram protocol assertions
// bound onto the top level
//****************************************
`timescale 1ns/1ps
`include "axi_sram_defs.svh"

module axi_sram_chk
	import axi_types_pkg::*;
(
	input logic  clk,
	input logic  rstn,
	input addr_t ar_addr_i,
	input logic  ar_valid_i,
	input logic  ar_ready_i,
	input logic  aw_valid_i,
	input logic  aw_ready_i,
	input logic  w_valid_i,
	input logic  w_ready_i,
	input data_t r_data_i,
	input resp_t r_resp_i,
	input logic  r_valid_i,
	input logic  r_ready_i,
	input resp_t b_resp_i,
	input logic  b_valid_i,
	input logic  b_ready_i
);

	// first address bit above the word index
	localparam int IDX_TOP = `MEM_WORDS_LOG2 + 2;

	// sticky, one per property
	logic r_hold_err;
	logic b_hold_err;
	logic excl_err;
	logic rdy_err;
	logic rlat_err;
	logic wlat_err;
	logic any_err;
	// read address above the array, answered without the wait
	logic ar_oob;

	initial begin
		r_hold_err = 1'b0;
		b_hold_err = 1'b0;
		excl_err   = 1'b0;
		rdy_err    = 1'b0;
		rlat_err   = 1'b0;
		wlat_err   = 1'b0;
	end

	assign any_err = r_hold_err | b_hold_err | excl_err | rdy_err | rlat_err | wlat_err;

	assign ar_oob = |ar_addr_i[`AXI_ADDR_W-1:IDX_TOP];

	// r held with frozen payload until taken
	r_hold: assert property (@(posedge clk) disable iff (rstn)
		r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i))
	else begin
		$error("r channel dropped or changed before ready");
		r_hold_err = 1'b1;
	end

	// same for b
	b_hold: assert property (@(posedge clk) disable iff (rstn)
		b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
	else begin
		$error("b channel dropped or changed before ready");
		b_hold_err = 1'b1;
	end

	// only one transaction, so never both
	rb_excl: assert property (@(posedge clk) disable iff (rstn)
		!(r_valid_i && b_valid_i))
	else begin
		$error("r and b valid together");
		excl_err = 1'b1;
	end

	// nothing accepted while a response waits
	rdy_low: assert property (@(posedge clk) disable iff (rstn)
		r_valid_i || b_valid_i |-> !ar_ready_i && !aw_ready_i && !w_ready_i)
	else begin
		$error("request ready while a response is held");
		rdy_err = 1'b1;
	end

	// in-range ar handshake to r valid
	rd_lat: assert property (@(posedge clk) disable iff (rstn)
		ar_valid_i && ar_ready_i && !ar_oob |-> ##(`READ_WAIT + 2) $rose(r_valid_i))
	else begin
		$error("read latency off");
		rlat_err = 1'b1;
	end

	// aw+w handshake to b valid, read not competing
	wr_lat: assert property (@(posedge clk) disable iff (rstn)
		aw_valid_i && aw_ready_i && w_valid_i && !ar_valid_i |-> ##3 $rose(b_valid_i))
	else begin
		$error("write latency off");
		wlat_err = 1'b1;
	end

endmodule

bind axi_sram_top axi_sram_chk u_chk (
	.clk        (clk),
	.rstn       (rstn),
	.ar_addr_i  (ar_addr_i),
	.ar_valid_i (ar_valid_i),
	.ar_ready_i (ar_ready_o),
	.aw_valid_i (aw_valid_i),
	.aw_ready_i (aw_ready_o),
	.w_valid_i  (w_valid_i),
	.w_ready_i  (w_ready_o),
	.r_data_i   (r_data_o),
	.r_resp_i   (r_resp_o),
	.r_valid_i  (r_valid_o),
	.r_ready_i  (r_ready_i),
	.b_resp_i   (b_resp_o),
	.b_valid_i  (b_valid_o),
	.b_ready_i  (b_ready_i)
);

/* tests/axi_sram_tb.sv */
//****************************************
// axi-lite sram testbench
// directed, random and race traffic
//****************************************
`timescale 1ns/1ps
`include "axi_sram_defs.svh"

module axi_sram_tb
	import axi_types_pkg::*;
();

	localparam int TMO = 64;
	// low words exercised, the rest stay untouched
	localparam int NW_LOG2 = 5;
	localparam int NW = 1 << NW_LOG2;
	// first address bit above the word index
	localparam int IDX_TOP = `MEM_WORDS_LOG2 + 2;
	localparam int N_RAND = 200;

	logic  clk;
	logic  rstn;
	addr_t ar_addr;
	logic  ar_valid;
	logic  ar_ready;
	data_t r_data;
	resp_t r_resp;
	logic  r_valid;
	logic  r_ready;
	addr_t aw_addr;
	logic  aw_valid;
	logic  aw_ready;
	data_t w_data;
	strb_t w_strb;
	logic  w_valid;
	logic  w_ready;
	resp_t b_resp;
	logic  b_valid;
	logic  b_ready;

	integer seed = 32'ha762;
	// expected contents of the low words
	data_t  ref_mem [NW];

	tb_clk_gen u_clk (
		.clk_o  (clk),
		.rstn_o (rstn)
	);

	axi_sram_top DUT (
		.clk        (clk),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr),
		.ar_valid_i (ar_valid),
		.ar_ready_o (ar_ready),
		.r_data_o   (r_data),
		.r_resp_o   (r_resp),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.aw_addr_i  (aw_addr),
		.aw_valid_i (aw_valid),
		.aw_ready_o (aw_ready),
		.w_data_i   (w_data),
		.w_strb_i   (w_strb),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.b_resp_o   (b_resp),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input data_t exp, input data_t act);
		assert (act === exp) else begin
			stop_run($sformatf("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act));
		end
	endtask

	task automatic report_timeout(input string what);
		stop_run($sformatf("timeout at %0t waiting for %s", $time, what));
	endtask

	// byte lanes replaced only where strobe is set
	function automatic data_t merge_bytes(data_t old, data_t nw, strb_t s);
		data_t res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (s[b]) begin
				res[8*b +: 8] = nw[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic bit out_of_range(addr_t a);
		return |a[`AXI_ADDR_W-1:IDX_TOP];
	endfunction

	// called right after a rising edge
	task automatic offer(input bit is_wr, input addr_t a, input data_t d, input strb_t s);
		if (is_wr) begin
			aw_addr  <= a;
			aw_valid <= 1'b1;
			w_data   <= d;
			w_strb   <= s;
			w_valid  <= 1'b1;
		end else begin
			ar_addr  <= a;
			ar_valid <= 1'b1;
		end
	endtask

	// address handshake, then response with optional back-pressure
	task automatic finish(input bit is_wr, input bit bad, input bit bp,
			output data_t rd, output resp_t rs);
		int   n;
		int   lat;
		logic vld;
		logic rdy;
		bit   seen;
		n = 0;
		seen = 1'b0;
		// writes and errored reads skip the read wait
		lat = (is_wr || bad) ? 3 : `READ_WAIT + 2;
		do begin
			@(posedge clk);
			n++;
			if (n > TMO) report_timeout("address ready");
		end while (!(is_wr ? aw_ready : ar_ready));
		if (is_wr) begin
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
		end else begin
			ar_valid <= 1'b0;
		end
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TMO) report_timeout("response handshake");
			vld = is_wr ? b_valid : r_valid;
			rdy = is_wr ? b_ready : r_ready;
			assert (!ar_ready && !aw_ready) else stop_run("request accepted while busy");
			assert (!(is_wr ? r_valid : b_valid)) else stop_run("response on wrong channel");
			// latency counted from the address handshake edge
			if (vld && !seen) begin
				check_val("response latency", data_t'(lat), data_t'(n));
				seen = 1'b1;
			end
			if (is_wr) begin
				b_ready <= bp ? 1'($random(seed)) : 1'b1;
			end else begin
				r_ready <= bp ? 1'($random(seed)) : 1'b1;
			end
		end while (!(vld && rdy));
		rd = r_data;
		rs = is_wr ? b_resp : r_resp;
	endtask

	task automatic complete_write(input addr_t a, input data_t d, input strb_t s, input bit bp);
		data_t rd;
		resp_t rs;
		bit    bad;
		bad = out_of_range(a);
		finish(1'b1, bad, bp, rd, rs);
		check_val("b_resp_o", data_t'(bad ? RESP_SLVERR : RESP_OKAY), data_t'(rs));
		if (!bad) begin
			ref_mem[a[NW_LOG2+1:2]] = merge_bytes(ref_mem[a[NW_LOG2+1:2]], d, s);
		end
	endtask

	task automatic complete_read(input addr_t a, input bit bp);
		data_t rd;
		resp_t rs;
		bit    bad;
		bad = out_of_range(a);
		finish(1'b0, bad, bp, rd, rs);
		check_val("r_resp_o", data_t'(bad ? RESP_SLVERR : RESP_OKAY), data_t'(rs));
		check_val("r_data_o", bad ? data_t'(0) : ref_mem[a[NW_LOG2+1:2]], rd);
	endtask

	task automatic do_write(input addr_t a, input data_t d, input strb_t s, input bit bp);
		offer(1'b1, a, d, s);
		complete_write(a, d, s, bp);
	endtask

	task automatic do_read(input addr_t a, input bit bp);
		offer(1'b0, a, data_t'(0), strb_t'(0));
		complete_read(a, bp);
	endtask

	// checker flags watched between edges
	always @(negedge clk) begin
		if (DUT.u_chk.any_err) stop_run("protocol checker raised an assertion");
	end

	initial begin
		logic [NW_LOG2-1:0] w;
		addr_t a;
		addr_t bad_a;
		data_t d;
		int    n;
		ar_addr  <= '0;
		ar_valid <= 1'b0;
		r_ready  <= 1'b0;
		aw_addr  <= '0;
		aw_valid <= 1'b0;
		w_data   <= '0;
		w_strb   <= '0;
		w_valid  <= 1'b0;
		b_ready  <= 1'b0;
		// readies low in reset, up right after
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TMO) report_timeout("readies after reset");
			assert (!r_valid && !b_valid) else stop_run("response valid around reset");
			if (rstn) begin
				assert (!ar_ready && !aw_ready && !w_ready) else stop_run("ready during reset");
			end
		end while (!ar_ready);
		assert (aw_ready && w_ready) else stop_run("write readies did not rise");
		repeat (8) begin
			@(posedge clk);
			assert (!r_valid && !b_valid) else stop_run("response valid without a request");
		end
		// fill, pattern from the whole address, each word read back
		for (int i = 0; i < NW; i++) begin
			a = addr_t'(i) << 2;
			do_write(a, a * 32'h9e37_79b1 + 32'h1234_5678, 4'hf, 1'b0);
			do_read(a, 1'b0);
		end
		// out-of-range alias must not touch the array
		for (int i = 0; i < 8; i++) begin
			w = NW_LOG2'($random(seed));
			a = addr_t'(w) << 2;
			bad_a = a | (addr_t'($random(seed)) << IDX_TOP) | (addr_t'(1) << (IDX_TOP + i));
			do_write(bad_a, data_t'($random(seed)), 4'hf, 1'b0);
			do_read(bad_a, 1'b0);
			do_read(a, 1'b0);
		end
		// random mix under back-pressure, low address bits ignored
		for (int i = 0; i < N_RAND; i++) begin
			w = NW_LOG2'($random(seed));
			a = (addr_t'(w) << 2) | addr_t'(2'($random(seed)));
			if (1'($random(seed))) begin
				do_write(a, data_t'($random(seed)), strb_t'($random(seed)), 1'b1);
			end else begin
				do_read(a, 1'b1);
			end
		end
		// read and write offered together, read goes first
		for (int i = 0; i < 4; i++) begin
			w = NW_LOG2'($random(seed));
			a = addr_t'(w) << 2;
			d = data_t'($random(seed));
			offer(1'b0, a, data_t'(0), strb_t'(0));
			offer(1'b1, a, d, 4'hf);
			complete_read(a, 1'b0);
			complete_write(a, d, 4'hf, 1'b0);
			do_read(a, 1'b0);
		end
		repeat (4) @(posedge clk);
		if (!DUT.u_chk.any_err) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_run("protocol checker raised an assertion");
		end
	end

endmodule

/* tests/tb_clk_gen.sv */
//****************************************
// testbench clock and reset source
//****************************************
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rstn_o
);

	// reset held for this many rising edges
	localparam int RST_CYCLES = 16;

	// 4 ns period
	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	// active high, released on an edge
	initial begin
		rstn_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rstn_o <= 1'b0;
	end

endmodule

/* verilog/axi_req_decode.sv */
//**************************************
// axi-lite request decoder
// read-first arbitration, range check
//**************************************
`timescale 1ns/1ps
`include "axi_sram_defs.svh"

module axi_req_decode
	import axi_types_pkg::*;
	import sram_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	// read address channel
	input  addr_t     ar_addr_i,
	input  logic      ar_valid_i,
	output logic      ar_ready_o,
	// write address channel
	input  addr_t     aw_addr_i,
	input  logic      aw_valid_i,
	output logic      aw_ready_o,
	// write data channel
	input  data_t     w_data_i,
	input  strb_t     w_strb_i,
	input  logic      w_valid_i,
	output logic      w_ready_o,
	// response taken by the master
	input  logic      free_i,
	mem_req_if.src    req
);

	// word index sits above the byte offset
	localparam int IDX_LO = 2;
	localparam int IDX_HI = `MEM_WORDS_LOG2 + 1;

	dec_state_e state;
	dec_state_e state_nxt;
	// readies, registered so they stay low in reset
	logic       rdy_q;
	logic       rd_acc;
	logic       wr_acc;
	addr_t      acc_addr;
	// latched request payload
	logic       we_q;
	logic       err_q;
	word_idx_t  idx_q;
	data_t      wdata_q;
	strb_t      strb_q;

	// one ready level for all three channels
	assign ar_ready_o = rdy_q;
	assign aw_ready_o = rdy_q;
	assign w_ready_o  = rdy_q;

	// read wins when both are offered
	assign rd_acc = rdy_q && ar_valid_i;
	// write needs aw and w together
	assign wr_acc = rdy_q && !ar_valid_i && aw_valid_i && w_valid_i;

	// address of whichever request is accepted
	assign acc_addr = rd_acc ? ar_addr_i : aw_addr_i;

	always_comb begin
		state_nxt = state;
		case (state)
			DEC_IDLE: begin
				if (rd_acc || wr_acc) begin
					state_nxt = DEC_ISSUE;
				end
			end
			DEC_ISSUE: begin
				state_nxt = DEC_BUSY;
			end
			DEC_BUSY: begin
				// held response taken, open up again
				if (free_i) begin
					state_nxt = DEC_IDLE;
				end
			end
			default: begin
				state_nxt = DEC_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			state <= DEC_IDLE;
			rdy_q <= 1'b0;
		end else begin
			state <= state_nxt;
			rdy_q <= (state_nxt == DEC_IDLE);
		end
	end

	// capture on the accepting handshake
	always_ff @(posedge clk) begin
		if (rd_acc || wr_acc) begin
			we_q  <= wr_acc;
			// any bit above the word index is out of range
			err_q <= |acc_addr[`AXI_ADDR_W-1:IDX_HI+1];
			idx_q <= acc_addr[IDX_HI:IDX_LO];
		end
		if (wr_acc) begin
			wdata_q <= w_data_i;
			strb_q  <= w_strb_i;
		end
	end

	// req one cycle after acceptance
	assign req.req   = (state == DEC_ISSUE);
	assign req.we    = we_q;
	assign req.err   = err_q;
	assign req.idx   = idx_q;
	assign req.wdata = wdata_q;
	assign req.strb  = strb_q;

endmodule

/* verilog/axi_resp_gen.sv */
//**************************************
// r and b channel holding registers
// frees decode on the final handshake
//**************************************
`timescale 1ns/1ps

module axi_resp_gen
	import axi_types_pkg::*;
(
	input  logic   clk,
	input  logic   rstn,
	// master side readies
	input  logic   r_ready_i,
	input  logic   b_ready_i,
	mem_rsp_if.snk rsp,
	// read data channel
	output data_t  r_data_o,
	output resp_t  r_resp_o,
	output logic   r_valid_o,
	// write response channel
	output resp_t  b_resp_o,
	output logic   b_valid_o,
	// held response taken
	output logic   free_o
);

	logic r_load;
	logic b_load;
	logic r_take;
	logic b_take;

	// done routes to one channel only
	assign r_load = rsp.done && rsp.is_read;
	assign b_load = rsp.done && !rsp.is_read;

	// handshakes on the bus side
	assign r_take = r_valid_o && r_ready_i;
	assign b_take = b_valid_o && b_ready_i;

	// one transaction in flight, so one take at a time
	assign free_o = r_take || b_take;

	// valids held until the master takes them
	always_ff @(posedge clk) begin
		if (rstn) begin
			r_valid_o <= 1'b0;
			b_valid_o <= 1'b0;
		end else begin
			if (r_load) begin
				r_valid_o <= 1'b1;
			end else if (r_take) begin
				r_valid_o <= 1'b0;
			end
			if (b_load) begin
				b_valid_o <= 1'b1;
			end else if (b_take) begin
				b_valid_o <= 1'b0;
			end
		end
	end

	// payload only changes on done, stable under back-pressure
	always_ff @(posedge clk) begin
		if (r_load) begin
			r_data_o <= rsp.rdata;
			r_resp_o <= rsp.resp;
		end
		if (b_load) begin
			b_resp_o <= rsp.resp;
		end
	end

endmodule

/* verilog/axi_sram_top.sv */
//**************************************
// axi-lite sram slave top level
// decode, execute and response blocks
//**************************************
`timescale 1ns/1ps
`include "axi_sram_defs.svh"

module axi_sram_top (
	input  logic                    clk,
	input  logic                    rstn,
	// read address
	input  logic [`AXI_ADDR_W-1:0]  ar_addr_i,
	input  logic                    ar_valid_i,
	output logic                    ar_ready_o,
	// read data
	output logic [`AXI_DATA_W-1:0]  r_data_o,
	output logic [1:0]              r_resp_o,
	output logic                    r_valid_o,
	input  logic                    r_ready_i,
	// write address
	input  logic [`AXI_ADDR_W-1:0]  aw_addr_i,
	input  logic                    aw_valid_i,
	output logic                    aw_ready_o,
	// write data
	input  logic [`AXI_DATA_W-1:0]  w_data_i,
	input  logic [`AXI_DATA_W/8-1:0] w_strb_i,
	input  logic                    w_valid_i,
	output logic                    w_ready_o,
	// write response
	output logic [1:0]              b_resp_o,
	output logic                    b_valid_o,
	input  logic                    b_ready_i
);

	// result back to decode
	logic free;

	mem_req_if u_req_if ();
	mem_rsp_if u_rsp_if ();

	axi_req_decode u_decode (
		.clk        (clk),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr_i),
		.ar_valid_i (ar_valid_i),
		.ar_ready_o (ar_ready_o),
		.aw_addr_i  (aw_addr_i),
		.aw_valid_i (aw_valid_i),
		.aw_ready_o (aw_ready_o),
		.w_data_i   (w_data_i),
		.w_strb_i   (w_strb_i),
		.w_valid_i  (w_valid_i),
		.w_ready_o  (w_ready_o),
		.free_i     (free),
		.req        (u_req_if.src)
	);

	sram_exec u_exec (
		.clk  (clk),
		.rstn (rstn),
		.req  (u_req_if.snk),
		.rsp  (u_rsp_if.src)
	);

	axi_resp_gen u_resp (
		.clk       (clk),
		.rstn      (rstn),
		.r_ready_i (r_ready_i),
		.b_ready_i (b_ready_i),
		.rsp       (u_rsp_if.snk),
		.r_data_o  (r_data_o),
		.r_resp_o  (r_resp_o),
		.r_valid_o (r_valid_o),
		.b_resp_o  (b_resp_o),
		.b_valid_o (b_valid_o),
		.free_o    (free)
	);

endmodule

/* verilog/axi_types_pkg.sv */
//**************************************
// axi-lite bus-side types
// address, data, strobe, response codes
//**************************************
`include "axi_sram_defs.svh"

package axi_types_pkg;

	// byte address as seen on ar/aw
	typedef logic [`AXI_ADDR_W-1:0] addr_t;

	// one data word on r/w
	typedef logic [`AXI_DATA_W-1:0] data_t;

	// one enable per byte lane
	typedef logic [`AXI_DATA_W/8-1:0] strb_t;

	// r/b response code
	typedef logic [1:0] resp_t;

	// access done normally
	localparam resp_t RESP_OKAY = 2'b00;
	// slave error, address out of range
	localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* verilog/mem_req_if.sv */
//**************************************
// checked memory request, decode to exec
//**************************************
`timescale 1ns/1ps

interface mem_req_if
	import axi_types_pkg::*;
	import sram_ctrl_pkg::*;
();

	// single-cycle request strobe
	logic      req;
	// 1 for write, 0 for read
	logic      we;
	// address above the array, no access
	logic      err;
	word_idx_t idx;
	data_t     wdata;
	strb_t     strb;

	// decode side
	modport src (output req, we, err, idx, wdata, strb);

	// execute side
	modport snk (input req, we, err, idx, wdata, strb);

endinterface

/* verilog/mem_rsp_if.sv */
//**************************************
// completed access, exec to result
//**************************************
`timescale 1ns/1ps

interface mem_rsp_if
	import axi_types_pkg::*;
();

	// single-cycle completion strobe
	logic  done;
	// selects r channel over b channel
	logic  is_read;
	data_t rdata;
	resp_t resp;

	// execute side
	modport src (output done, is_read, rdata, resp);

	// result side
	modport snk (input done, is_read, rdata, resp);

endinterface

/* verilog/sram_ctrl_pkg.sv */
//**************************************
// sram controller-side types
// decode fsm states and word index
//**************************************
`include "axi_sram_defs.svh"

package sram_ctrl_pkg;

	// index of one word in the array
	typedef logic [`MEM_WORDS_LOG2-1:0] word_idx_t;

	// decode fsm
	// idle: readies up, waiting for ar or aw+w
	// issue: one-cycle req towards execute
	// busy: waiting for result to hand back free
	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_ISSUE,
		DEC_BUSY
	} dec_state_e;

endpackage

/* verilog/sram_exec.sv */
//**************************************
// byte-strobed sram array
// fixed read wait, one done per request
//**************************************
`timescale 1ns/1ps
`include "axi_sram_defs.svh"

module sram_exec
	import axi_types_pkg::*;
	import sram_ctrl_pkg::*;
(
	input  logic   clk,
	input  logic   rstn,
	mem_req_if.snk req,
	mem_rsp_if.src rsp
);

	localparam int DEPTH = 1 << `MEM_WORDS_LOG2;
	localparam int CNT_W = $clog2(`READ_WAIT + 1);
	// counter starts at 1 the cycle after req
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`READ_WAIT - 1);

	data_t            mem [DEPTH];
	logic             rd_busy;
	logic [CNT_W-1:0] cnt;
	word_idx_t        rd_idx;
	// read wait over, word goes out
	logic             rd_fire;
	// request that answers on the next cycle
	logic             quick;

	assign rd_fire = rd_busy && (cnt == CNT_LAST);
	// writes and errored requests skip the wait
	assign quick   = req.req && (req.we || req.err);

	// byte lanes only where strobe is set
	always_ff @(posedge clk) begin
		if (req.req && req.we && !req.err) begin
			for (int b = 0; b < $bits(strb_t); b++) begin
				if (req.strb[b]) begin
					mem[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
				end
			end
		end
	end

	// read wait counter and completion strobe
	always_ff @(posedge clk) begin
		if (rstn) begin
			rd_busy  <= 1'b0;
			cnt      <= '0;
			rsp.done <= 1'b0;
		end else begin
			rsp.done <= quick || rd_fire;
			if (req.req && !req.we && !req.err) begin
				rd_busy <= 1'b1;
				cnt     <= CNT_W'(1);
			end else if (rd_fire) begin
				rd_busy <= 1'b0;
			end else if (rd_busy) begin
				cnt <= cnt + CNT_W'(1);
			end
		end
	end

	// response payload, valid alongside done
	always_ff @(posedge clk) begin
		if (req.req) begin
			rsp.is_read <= !req.we;
			rd_idx      <= req.idx;
		end
		if (rd_fire) begin
			rsp.rdata <= mem[rd_idx];
			rsp.resp  <= RESP_OKAY;
		end else if (quick) begin
			// error read returns zero data
			rsp.rdata <= '0;
			rsp.resp  <= req.err ? RESP_SLVERR : RESP_OKAY;
		end
	end

endmodule

/* vlog.f */
+incdir+include
verilog/axi_types_pkg.sv
verilog/sram_ctrl_pkg.sv
verilog/mem_req_if.sv
verilog/mem_rsp_if.sv
verilog/axi_req_decode.sv
verilog/sram_exec.sv
verilog/axi_resp_gen.sv
verilog/axi_sram_top.sv
tests/tb_clk_gen.sv
tests/axi_sram_chk.sv
tests/axi_sram_tb.sv
